// ==== hw/basics_config.svh ====
`ifndef BASICS_CONFIG_SVH
`define BASICS_CONFIG_SVH

// Supported protocol version
`define BASICS_VERSION_MAJOR 8'h00
`define BASICS_VERSION_MINOR 8'h05

// First byte of a reply frame
`define BASICS_ACK_CODE 8'h2B
`define BASICS_NAK_CODE 8'h7E

// Command bytes
`define BASICS_CMD_VER      8'h76
`define BASICS_CMD_QRY_I2C  8'h49
`define BASICS_CMD_SET_I2C  8'h69
`define BASICS_CMD_QRY_GPIO 8'h47
`define BASICS_CMD_SET_GPIO 8'h67

// Selector bytes, first payload byte of a query or set
`define BASICS_SEL_SPEED "c"
`define BASICS_SEL_ADDR  "a"
`define BASICS_SEL_LEVEL "l"
`define BASICS_SEL_DIR   "d"
`define BASICS_SEL_INTEN "i"
// Input pins, query only
`define BASICS_SEL_READ  "r"

`define BASICS_GPIO_W 24

// Settings after reset
`define BASICS_RST_I2C_SPEED 8'd99
`define BASICS_RST_I2C_ADDR  16'hFFFF
`define BASICS_RST_GPIO      24'h000000

`endif

// ==== hw/basics_pkg.sv ====
`include "basics_config.svh"

package basics_pkg;

	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_VER,
		CMD_QRY_I2C,
		CMD_SET_I2C,
		CMD_QRY_GPIO,
		CMD_SET_GPIO
	} cmd_e;

	typedef enum logic [2:0] {
		PAR_NONE,
		PAR_I2C_SPEED,
		PAR_I2C_ADDR,
		PAR_GPIO_LEVEL,
		PAR_GPIO_DIR,
		PAR_GPIO_INTEN,
		PAR_GPIO_READ
	} param_e;

	// Right-aligned, only the low param_len bytes carry data
	typedef logic [`BASICS_GPIO_W-1:0] word_t;

	function automatic logic [1:0] param_len(param_e sel);
		case (sel)
			PAR_I2C_SPEED: return 2'd1;
			PAR_I2C_ADDR: return 2'd2;
			PAR_GPIO_LEVEL, PAR_GPIO_DIR, PAR_GPIO_INTEN, PAR_GPIO_READ: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	function automatic logic is_query(cmd_e cmd);
		return (cmd == CMD_QRY_I2C) || (cmd == CMD_QRY_GPIO);
	endfunction

	function automatic logic is_gpio(cmd_e cmd);
		return (cmd == CMD_QRY_GPIO) || (cmd == CMD_SET_GPIO);
	endfunction

endpackage

// ==== hw/basics_ifs.sv ====
`timescale 1ns/1ps

// Decoded frame events from the receiver
interface rx_cmd_if;
	import basics_pkg::*;

	logic hdr_valid;
	cmd_e cmd;
	logic [7:0] eid;
	logic pay_valid;
	logic [7:0] pay_data;
	logic frame_end;

	modport src (output hdr_valid, cmd, eid, pay_valid, pay_data, frame_end);
	modport dst (input hdr_valid, cmd, eid, pay_valid, pay_data, frame_end);
endinterface

// Parameter access, staged writes and combinational read
interface param_if;
	import basics_pkg::*;

	param_e sel;
	logic wr_strobe;
	logic [7:0] wr_data;
	logic commit;
	logic discard;
	word_t rd_word;

	modport ctrl (output sel, wr_strobe, wr_data, commit, discard, input rd_word);
	modport bank (input sel, wr_strobe, wr_data, commit, discard, output rd_word);
endinterface

// Reply request to the output framer
interface reply_if;
	import basics_pkg::*;

	logic start;
	logic nak;
	logic [7:0] eid;
	word_t data;
	logic [1:0] data_len;
	logic done;

	modport ctrl (output start, nak, eid, data, data_len, input done);
	modport framer (input start, nak, eid, data, data_len, output done);
endinterface

// ==== hw/cmd_frame_rx.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module cmd_frame_rx (
	input logic clk,
	input logic rst,
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,
	rx_cmd_if.src rx
);
	import basics_pkg::*;

	// Byte position in the frame, stops at 3 for all payload bytes
	logic [1:0] byte_cnt;
	logic frame_q;
	cmd_e cmd_dec;
	logic byte_in;

	assign byte_in = ma_frame_valid && ma_data_valid;

	always_comb begin
		case (ma_data)
			`BASICS_CMD_VER: cmd_dec = CMD_VER;
			`BASICS_CMD_QRY_I2C: cmd_dec = CMD_QRY_I2C;
			`BASICS_CMD_SET_I2C: cmd_dec = CMD_SET_I2C;
			`BASICS_CMD_QRY_GPIO: cmd_dec = CMD_QRY_GPIO;
			`BASICS_CMD_SET_GPIO: cmd_dec = CMD_SET_GPIO;
			default: cmd_dec = CMD_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt <= 2'd0;
			frame_q <= 1'b0;
			rx.cmd <= CMD_NONE;
			rx.hdr_valid <= 1'b0;
			rx.pay_valid <= 1'b0;
			rx.frame_end <= 1'b0;
		end else begin
			frame_q <= ma_frame_valid;
			rx.frame_end <= frame_q && !ma_frame_valid;
			rx.hdr_valid <= byte_in && (byte_cnt == 2'd2);
			rx.pay_valid <= byte_in && (byte_cnt == 2'd3);
			if (!ma_frame_valid) begin
				byte_cnt <= 2'd0;
			end else if (ma_data_valid && byte_cnt != 2'd3) begin
				byte_cnt <= byte_cnt + 2'd1;
			end
			if (byte_in && byte_cnt == 2'd0) begin
				rx.cmd <= cmd_dec;
			end
		end
	end

	// EID and payload bytes
	always_ff @(posedge clk) begin
		if (byte_in) begin
			if (byte_cnt == 2'd1) begin
				rx.eid <= ma_data;
			end
			rx.pay_data <= ma_data;
		end
	end

endmodule

// ==== hw/param_bank.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module param_bank (
	input logic clk,
	input logic rst,
	input logic [`BASICS_GPIO_W-1:0] gpio_read,
	param_if.bank p,
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,
	output logic [`BASICS_GPIO_W-1:0] gpio_level,
	output logic [`BASICS_GPIO_W-1:0] gpio_direction,
	output logic [`BASICS_GPIO_W-1:0] gpio_int_enable
);
	import basics_pkg::*;

	// Staging copies, written byte by byte and copied live on commit
	logic [7:0] speed_stg;
	logic [15:0] addr_stg;
	word_t level_stg;
	word_t dir_stg;
	word_t inten_stg;

	always_ff @(posedge clk) begin
		if (rst) begin
			speed_stg <= `BASICS_RST_I2C_SPEED;
			addr_stg <= `BASICS_RST_I2C_ADDR;
			level_stg <= `BASICS_RST_GPIO;
			dir_stg <= `BASICS_RST_GPIO;
			inten_stg <= `BASICS_RST_GPIO;
			i2c_speed <= `BASICS_RST_I2C_SPEED;
			i2c_addr <= `BASICS_RST_I2C_ADDR;
			gpio_level <= `BASICS_RST_GPIO;
			gpio_direction <= `BASICS_RST_GPIO;
			gpio_int_enable <= `BASICS_RST_GPIO;
		end else if (p.discard) begin
			speed_stg <= i2c_speed;
			addr_stg <= i2c_addr;
			level_stg <= gpio_level;
			dir_stg <= gpio_direction;
			inten_stg <= gpio_int_enable;
		end else begin
			if (p.commit) begin
				i2c_speed <= speed_stg;
				i2c_addr <= addr_stg;
				gpio_level <= level_stg;
				gpio_direction <= dir_stg;
				gpio_int_enable <= inten_stg;
			end
			// Most significant byte arrives first
			if (p.wr_strobe) begin
				case (p.sel)
					PAR_I2C_SPEED: speed_stg <= p.wr_data;
					PAR_I2C_ADDR: addr_stg <= {addr_stg[7:0], p.wr_data};
					PAR_GPIO_LEVEL: level_stg <= {level_stg[15:0], p.wr_data};
					PAR_GPIO_DIR: dir_stg <= {dir_stg[15:0], p.wr_data};
					PAR_GPIO_INTEN: inten_stg <= {inten_stg[15:0], p.wr_data};
					default: ;
				endcase
			end
		end
	end

	// Read side always shows live values
	always_comb begin
		case (p.sel)
			PAR_I2C_SPEED: p.rd_word = {16'h0000, i2c_speed};
			PAR_I2C_ADDR: p.rd_word = {8'h00, i2c_addr};
			PAR_GPIO_LEVEL: p.rd_word = gpio_level;
			PAR_GPIO_DIR: p.rd_word = gpio_direction;
			PAR_GPIO_INTEN: p.rd_word = gpio_int_enable;
			PAR_GPIO_READ: p.rd_word = gpio_read;
			default: p.rd_word = '0;
		endcase
	end

endmodule

// ==== hw/basics_ctrl.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module basics_ctrl (
	input logic clk,
	input logic rst,
	rx_cmd_if.dst rx,
	param_if.ctrl p,
	reply_if.ctrl reply
);
	import basics_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_VER, S_SEL, S_SETB, S_WAIT, S_COMMIT} state_e;

	state_e state;
	state_e next_state;
	cmd_e cmd_q;
	param_e sel_q;
	param_e sel_dec;
	logic [7:0] ver_hi;
	logic ver_cnt;
	logic [1:0] byte_cnt;
	logic commit_pend;
	logic sel_ok;
	logic send;
	logic send_nak;
	word_t send_data;
	logic [1:0] send_len;

	// Selector meaning depends on the command group
	always_comb begin
		sel_dec = PAR_NONE;
		if (is_gpio(cmd_q)) begin
			case (rx.pay_data)
				`BASICS_SEL_LEVEL: sel_dec = PAR_GPIO_LEVEL;
				`BASICS_SEL_DIR: sel_dec = PAR_GPIO_DIR;
				`BASICS_SEL_INTEN: sel_dec = PAR_GPIO_INTEN;
				`BASICS_SEL_READ: sel_dec = PAR_GPIO_READ;
				default: sel_dec = PAR_NONE;
			endcase
		end else begin
			case (rx.pay_data)
				`BASICS_SEL_SPEED: sel_dec = PAR_I2C_SPEED;
				`BASICS_SEL_ADDR: sel_dec = PAR_I2C_ADDR;
				default: sel_dec = PAR_NONE;
			endcase
		end
	end

	// Pin readback cannot be set
	assign sel_ok = (sel_dec != PAR_NONE) && (is_query(cmd_q) || sel_dec != PAR_GPIO_READ);

	// Selector is decoded in place so a query reads in the same cycle
	assign p.sel = (state == S_SEL) ? sel_dec : sel_q;
	assign p.wr_strobe = (state == S_SETB) && rx.pay_valid;
	assign p.wr_data = rx.pay_data;
	assign p.commit = (state == S_COMMIT);

	always_comb begin
		next_state = state;
		send = 1'b0;
		send_nak = 1'b0;
		send_data = '0;
		send_len = 2'd0;
		p.discard = 1'b0;
		case (state)
			S_IDLE: begin
				if (rx.hdr_valid && rx.cmd != CMD_NONE) begin
					next_state = (rx.cmd == CMD_VER) ? S_VER : S_SEL;
				end
			end
			S_VER: begin
				if ((rx.pay_valid && ver_cnt) || rx.frame_end) begin
					send = 1'b1;
					next_state = S_WAIT;
					if (!rx.pay_valid ||
						{ver_hi, rx.pay_data} != {`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR}) begin
						send_nak = 1'b1;
						send_data = {8'h00, `BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR};
						send_len = 2'd2;
					end
				end
			end
			S_SEL: begin
				if (rx.pay_valid) begin
					if (!sel_ok) begin
						send = 1'b1;
						send_nak = 1'b1;
						p.discard = 1'b1;
						next_state = S_WAIT;
					end else if (is_query(cmd_q)) begin
						send = 1'b1;
						send_data = p.rd_word;
						send_len = param_len(sel_dec);
						next_state = S_WAIT;
					end else begin
						next_state = S_SETB;
					end
				end else if (rx.frame_end) begin
					send = 1'b1;
					send_nak = 1'b1;
					p.discard = 1'b1;
					next_state = S_WAIT;
				end
			end
			S_SETB: begin
				if (rx.pay_valid) begin
					if (byte_cnt == param_len(sel_q) - 2'd1) begin
						send = 1'b1;
						next_state = S_WAIT;
					end
				end else if (rx.frame_end) begin
					send = 1'b1;
					send_nak = 1'b1;
					p.discard = 1'b1;
					next_state = S_WAIT;
				end
			end
			S_WAIT: begin
				if (reply.done) begin
					next_state = commit_pend ? S_COMMIT : S_IDLE;
				end
			end
			S_COMMIT: next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			cmd_q <= CMD_NONE;
			sel_q <= PAR_NONE;
			ver_cnt <= 1'b0;
			byte_cnt <= 2'd0;
			commit_pend <= 1'b0;
			reply.start <= 1'b0;
		end else begin
			state <= next_state;
			reply.start <= send;
			if (state == S_IDLE && rx.hdr_valid) begin
				cmd_q <= rx.cmd;
				ver_cnt <= 1'b0;
				commit_pend <= 1'b0;
			end
			if (state == S_VER && rx.pay_valid) begin
				ver_cnt <= 1'b1;
			end
			if (state == S_SEL && rx.pay_valid) begin
				sel_q <= sel_dec;
				byte_cnt <= 2'd0;
			end
			if (p.wr_strobe) begin
				byte_cnt <= byte_cnt + 2'd1;
			end
			// Settings go live only after a clean ACK
			if (state == S_SETB && send && !send_nak) begin
				commit_pend <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && rx.hdr_valid) begin
			reply.eid <= rx.eid;
		end
		if (state == S_VER && rx.pay_valid) begin
			ver_hi <= rx.pay_data;
		end
		if (send) begin
			reply.nak <= send_nak;
			reply.data <= send_data;
			reply.data_len <= send_len;
		end
	end

endmodule

// ==== hw/reply_framer.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module reply_framer (
	input logic clk,
	input logic rst,
	reply_if.framer reply,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_frame
);
	import basics_pkg::*;

	// State names the frame whose byte is on the output now
	typedef enum logic [1:0] {F_IDLE, F_HDR, F_GAP, F_DATA} fstate_e;

	fstate_e st;
	logic [2:0] idx;
	logic [2:0] last_idx;
	logic [7:0] eid_q;
	logic [1:0] len_q;
	word_t word_q;

	// Data frame is EID, length, then len_q bytes
	assign last_idx = {1'b0, len_q} + 3'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			st <= F_IDLE;
			idx <= 3'd0;
			out_valid <= 1'b0;
			out_frame <= 1'b0;
			reply.done <= 1'b0;
		end else begin
			reply.done <= 1'b0;
			case (st)
				F_IDLE: begin
					if (reply.start) begin
						st <= F_HDR;
						idx <= 3'd0;
						out_valid <= 1'b1;
						out_frame <= 1'b1;
					end
				end
				F_HDR: begin
					if (idx != 3'd2) begin
						idx <= idx + 3'd1;
					end else begin
						out_valid <= 1'b0;
						out_frame <= 1'b0;
						if (len_q == 2'd0) begin
							reply.done <= 1'b1;
							st <= F_IDLE;
						end else begin
							st <= F_GAP;
						end
					end
				end
				F_GAP: begin
					st <= F_DATA;
					idx <= 3'd0;
					out_valid <= 1'b1;
					out_frame <= 1'b1;
				end
				F_DATA: begin
					if (idx != last_idx) begin
						idx <= idx + 3'd1;
					end else begin
						out_valid <= 1'b0;
						out_frame <= 1'b0;
						reply.done <= 1'b1;
						st <= F_IDLE;
					end
				end
			endcase
		end
	end

	// Byte path, loads the byte for the next cycle
	always_ff @(posedge clk) begin
		case (st)
			F_IDLE: begin
				if (reply.start) begin
					out_data <= reply.nak ? `BASICS_NAK_CODE : `BASICS_ACK_CODE;
					eid_q <= reply.eid;
					len_q <= reply.data_len;
					// Left-align so the top byte goes first
					word_q <= reply.data << {2'd3 - reply.data_len, 3'b000};
				end
			end
			F_HDR: out_data <= (idx == 3'd0) ? eid_q : 8'h00;
			F_GAP: out_data <= eid_q;
			F_DATA: begin
				if (idx == 3'd0) begin
					out_data <= {6'd0, len_q};
				end else begin
					out_data <= word_q[23:16];
					word_q <= word_q << 8;
				end
			end
		endcase
	end

endmodule

// ==== hw/basics_int.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module basics_int (
	input logic clk,
	input logic rst,

	// Host command stream
	input logic [7:0] ma_data,
	input logic ma_data_valid,
	input logic ma_frame_valid,

	// GPIO pins and settings
	input logic [`BASICS_GPIO_W-1:0] gpio_read,
	output logic [`BASICS_GPIO_W-1:0] gpio_level,
	output logic [`BASICS_GPIO_W-1:0] gpio_direction,
	output logic [`BASICS_GPIO_W-1:0] gpio_int_enable,

	// I2C settings
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,

	// Reply stream
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_frame
);

	rx_cmd_if rx_bus ();
	param_if param_bus ();
	reply_if reply_bus ();

	cmd_frame_rx rx0 (
		.clk(clk),
		.rst(rst),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.rx(rx_bus.src)
	);

	basics_ctrl ctrl0 (
		.clk(clk),
		.rst(rst),
		.rx(rx_bus.dst),
		.p(param_bus.ctrl),
		.reply(reply_bus.ctrl)
	);

	param_bank bank0 (
		.clk(clk),
		.rst(rst),
		.gpio_read(gpio_read),
		.p(param_bus.bank),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	reply_framer framer0 (
		.clk(clk),
		.rst(rst),
		.reply(reply_bus.framer),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_frame(out_frame)
	);

endmodule

// ==== verification/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
	input logic clk,
	input logic rst,
	input logic [7:0] out_data,
	input logic out_valid,
	input logic out_frame,
	input logic [7:0] i2c_speed,
	input logic [15:0] i2c_addr,
	input logic [23:0] gpio_level,
	input logic [23:0] gpio_direction,
	input logic [23:0] gpio_int_enable
);
	// Expected bytes in order with frame lengths marking the boundaries
	logic [7:0] exp_bytes[$];
	int exp_lens[$];
	int open_len = 0;
	logic [7:0] got[$];
	string cur_test = "none";
	int test_errors = 0;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;

	function automatic void expect_byte(logic [7:0] b);
		exp_bytes.push_back(b);
		open_len++;
	endfunction

	function automatic void expect_end();
		exp_lens.push_back(open_len);
		open_len = 0;
	endfunction

	function automatic int pending();
		return exp_lens.size();
	endfunction

	function automatic void begin_test(string name);
		cur_test = name;
		test_errors = 0;
	endfunction

	function automatic void end_test();
		if (test_errors == 0) begin
			$display("pass %s", cur_test);
			pass_count++;
		end else begin
			$display("fail %s with %0d errors", cur_test, test_errors);
			fail_count++;
		end
	endfunction

	function automatic void report_value(string exp_s, string act_s);
		$display("error %s expected %s actual %s", cur_test, exp_s, act_s);
		test_errors++;
		error_count++;
	endfunction

	function automatic void report_other(string msg);
		$display("%s: %s", cur_test, msg);
		test_errors++;
		error_count++;
	endfunction

	function automatic void missing_reply();
		report_other("no reply frame before timeout");
		exp_bytes.delete();
		exp_lens.delete();
	endfunction

	// Setting ports use the same numbering as the selector codes
	function automatic void check_setting(int code, logic [23:0] exp);
		logic [23:0] act;
		case (code)
			1: act = {16'h0000, i2c_speed};
			2: act = {8'h00, i2c_addr};
			3: act = gpio_level;
			4: act = gpio_direction;
			5: act = gpio_int_enable;
			default: act = 24'h000000;
		endcase
		if (act !== exp) begin
			report_value($sformatf("%06h", exp), $sformatf("%06h", act));
		end
	endfunction

	function automatic void compare_frame();
		string exp_s;
		string act_s;
		logic [7:0] b;
		logic match;
		int len;
		int i;
		exp_s = "";
		act_s = "";
		match = 1'b1;
		for (i = 0; i < got.size(); i++) begin
			act_s = {act_s, $sformatf("%02h", got[i])};
		end
		if (exp_lens.size() == 0) begin
			report_other($sformatf("unexpected reply frame %s", act_s));
		end else begin
			len = exp_lens.pop_front();
			if (len != got.size()) begin
				match = 1'b0;
			end
			for (i = 0; i < len; i++) begin
				b = exp_bytes.pop_front();
				exp_s = {exp_s, $sformatf("%02h", b)};
				if (i >= got.size() || got[i] !== b) begin
					match = 1'b0;
				end
			end
			if (!match) begin
				report_value(exp_s, act_s);
			end
		end
		got.delete();
	endfunction

	// Collect while the frame is up and compare once it drops
	always @(posedge clk) begin
		if (rst) begin
			got.delete();
		end else begin
			// Every byte has valid and frame high together, the gap has both low
			if (out_valid !== out_frame) begin
				report_other("out_valid and out_frame differ");
			end
			if (out_valid && out_frame) begin
				got.push_back(out_data);
			end else if (got.size() != 0) begin
				compare_frame();
			end
		end
	end

endmodule

// ==== verification/tb_basics.sv ====
`timescale 1ns/1ps
`include "basics_config.svh"

module tb_basics;
	localparam int NUM_TESTS = 19;
	localparam int CYCLE_LIMIT = NUM_TESTS * 64 + 2;
	localparam int REPLY_WAIT = 64;
	localparam int QUIET = 24;

	logic clk = 1'b0;
	logic rst;
	logic [7:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic [23:0] gpio_read;
	logic [7:0] i2c_speed;
	logic [15:0] i2c_addr;
	logic [23:0] gpio_level;
	logic [23:0] gpio_direction;
	logic [23:0] gpio_int_enable;
	logic [7:0] out_data;
	logic out_valid;
	logic out_frame;

	logic [31:0] lcg_state;
	int cycle_cnt = 0;
	// Model of the live settings
	logic [7:0] m_speed;
	logic [15:0] m_addr;
	logic [23:0] m_level;
	logic [23:0] m_dir;
	logic [23:0] m_inten;
	// Command frame to send and the frames expected back
	logic [7:0] tx[$];
	logic [7:0] ref_bytes[$];
	int ref_lens[$];

	always #20 clk = ~clk;

	basics_int dut0 (
		.clk(clk),
		.rst(rst),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.gpio_read(gpio_read),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_frame(out_frame)
	);

	tb_checker chk0 (
		.clk(clk),
		.rst(rst),
		.out_data(out_data),
		.out_valid(out_valid),
		.out_frame(out_frame),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles before all tests finished", cycle_cnt);
			$display("TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic logic [23:0] rand24();
		logic [31:0] r;
		r = lcg_next();
		return r[31:8];
	endfunction

	// 1 speed, 2 address, 3 level, 4 direction, 5 int enable, 6 input pins
	function automatic int sel_code(logic gpio, logic [7:0] sel);
		if (gpio) begin
			case (sel)
				`BASICS_SEL_LEVEL: return 3;
				`BASICS_SEL_DIR: return 4;
				`BASICS_SEL_INTEN: return 5;
				`BASICS_SEL_READ: return 6;
				default: return 0;
			endcase
		end
		case (sel)
			`BASICS_SEL_SPEED: return 1;
			`BASICS_SEL_ADDR: return 2;
			default: return 0;
		endcase
	endfunction

	function automatic int code_len(int code);
		if (code == 0) begin
			return 0;
		end
		return (code < 3) ? code : 3;
	endfunction

	function automatic logic [23:0] model_value(int code);
		case (code)
			1: return {16'h0000, m_speed};
			2: return {8'h00, m_addr};
			3: return m_level;
			4: return m_dir;
			5: return m_inten;
			6: return gpio_read;
			default: return 24'h000000;
		endcase
	endfunction

	function automatic void model_write(int code, logic [23:0] val);
		case (code)
			1: m_speed = val[7:0];
			2: m_addr = val[15:0];
			3: m_level = val;
			4: m_dir = val;
			5: m_inten = val;
			default: ;
		endcase
	endfunction

	function automatic void add_reply(logic [7:0] eid, logic nak);
		ref_bytes.push_back(nak ? `BASICS_NAK_CODE : `BASICS_ACK_CODE);
		ref_bytes.push_back(eid);
		ref_bytes.push_back(8'h00);
		ref_lens.push_back(3);
	endfunction

	// Data frame is EID, length, then the bytes top first
	function automatic void add_data(logic [7:0] eid, int len, logic [23:0] word);
		int i;
		ref_bytes.push_back(eid);
		ref_bytes.push_back(8'(len));
		for (i = len - 1; i >= 0; i--) begin
			ref_bytes.push_back(word[i*8 +: 8]);
		end
		ref_lens.push_back(len + 2);
	endfunction

	// Builds the expected frames for the command in tx and updates the model on a good set
	function automatic int reference_reply();
		logic [7:0] cmd;
		logic [7:0] eid;
		logic [23:0] val;
		logic is_qry;
		logic is_set;
		int npay;
		int code;
		int len;
		int i;
		cmd = tx[0];
		eid = tx[1];
		npay = tx.size() - 3;
		is_qry = (cmd == `BASICS_CMD_QRY_I2C) || (cmd == `BASICS_CMD_QRY_GPIO);
		is_set = (cmd == `BASICS_CMD_SET_I2C) || (cmd == `BASICS_CMD_SET_GPIO);
		if (cmd == `BASICS_CMD_VER) begin
			if (npay >= 2 && tx[3] == `BASICS_VERSION_MAJOR && tx[4] == `BASICS_VERSION_MINOR) begin
				add_reply(eid, 1'b0);
			end else begin
				add_reply(eid, 1'b1);
				add_data(eid, 2, {8'h00, `BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR});
			end
		end else if (is_qry || is_set) begin
			code = 0;
			if (npay > 0) begin
				code = sel_code(cmd == `BASICS_CMD_QRY_GPIO || cmd == `BASICS_CMD_SET_GPIO, tx[3]);
			end
			len = code_len(code);
			if (code == 0 || (is_set && (code == 6 || npay - 1 < len))) begin
				add_reply(eid, 1'b1);
			end else if (is_qry) begin
				add_reply(eid, 1'b0);
				add_data(eid, len, model_value(code));
			end else begin
				val = 24'h000000;
				for (i = 0; i < len; i++) begin
					val = {val[15:0], tx[4 + i]};
				end
				add_reply(eid, 1'b0);
				model_write(code, val);
			end
		end
		return ref_lens.size();
	endfunction

	task automatic begin_frame(input logic [7:0] cmd);
		logic [31:0] r;
		r = lcg_next();
		tx.delete();
		tx.push_back(cmd);
		tx.push_back(r[23:16]);
		tx.push_back(8'h00);
	endtask

	task automatic send_frame();
		int i;
		tx[2] = 8'(tx.size() - 3);
		for (i = 0; i < tx.size(); i++) begin
			@(posedge clk);
			#2;
			ma_frame_valid = 1'b1;
			ma_data_valid = 1'b1;
			ma_data = tx[i];
		end
		@(posedge clk);
		#2;
		ma_frame_valid = 1'b0;
		ma_data_valid = 1'b0;
		ma_data = 8'h00;
	endtask

	task automatic drive_pins(input logic [23:0] val);
		@(posedge clk);
		#2;
		gpio_read = val;
	endtask

	task automatic run_cmd();
		int nf;
		int i;
		int k;
		int pos;
		ref_bytes.delete();
		ref_lens.delete();
		nf = reference_reply();
		pos = 0;
		for (i = 0; i < nf; i++) begin
			for (k = 0; k < ref_lens[i]; k++) begin
				chk0.expect_byte(ref_bytes[pos]);
				pos++;
			end
			chk0.expect_end();
		end
		send_frame();
		if (nf == 0) begin
			// Nothing should come back
			repeat (QUIET) @(negedge clk);
		end else begin
			i = 0;
			while (chk0.pending() != 0 && i < REPLY_WAIT) begin
				@(negedge clk);
				i++;
			end
			if (chk0.pending() != 0) begin
				chk0.missing_reply();
			end
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic send_query(input logic [7:0] cmd, input logic [7:0] sel);
		begin_frame(cmd);
		tx.push_back(sel);
		run_cmd();
	endtask

	task automatic send_set(input logic [7:0] cmd, input logic [7:0] sel,
		input logic [23:0] val, input int nbytes);
		int i;
		begin_frame(cmd);
		tx.push_back(sel);
		for (i = nbytes - 1; i >= 0; i--) begin
			tx.push_back(val[i*8 +: 8]);
		end
		run_cmd();
	endtask

	task automatic send_version(input logic [7:0] major, input logic [7:0] minor);
		begin_frame(`BASICS_CMD_VER);
		tx.push_back(major);
		tx.push_back(minor);
		run_cmd();
	endtask

	task automatic query_test(input string name, input logic [7:0] cmd, input logic [7:0] sel);
		chk0.begin_test(name);
		send_query(cmd, sel);
		chk0.end_test();
	endtask

	task automatic set_then_query(input string name, input logic gpio,
		input logic [7:0] sel, input int code);
		logic [23:0] val;
		chk0.begin_test(name);
		val = rand24() >> (8 * (3 - code_len(code)));
		send_set(gpio ? `BASICS_CMD_SET_GPIO : `BASICS_CMD_SET_I2C, sel, val, code_len(code));
		chk0.check_setting(code, model_value(code));
		send_query(gpio ? `BASICS_CMD_QRY_GPIO : `BASICS_CMD_QRY_I2C, sel);
		chk0.end_test();
	endtask

	initial begin
		lcg_state = 32'd52;
		rst = 1'b1;
		ma_data = 8'h00;
		ma_data_valid = 1'b0;
		ma_frame_valid = 1'b0;
		gpio_read = 24'h000000;
		m_speed = `BASICS_RST_I2C_SPEED;
		m_addr = `BASICS_RST_I2C_ADDR;
		m_level = `BASICS_RST_GPIO;
		m_dir = `BASICS_RST_GPIO;
		m_inten = `BASICS_RST_GPIO;
		repeat (2) @(posedge clk);
		#2;
		rst = 1'b0;

		query_test("reset_i2c_speed", `BASICS_CMD_QRY_I2C, `BASICS_SEL_SPEED);
		query_test("reset_i2c_addr", `BASICS_CMD_QRY_I2C, `BASICS_SEL_ADDR);
		query_test("reset_gpio_level", `BASICS_CMD_QRY_GPIO, `BASICS_SEL_LEVEL);
		query_test("reset_gpio_dir", `BASICS_CMD_QRY_GPIO, `BASICS_SEL_DIR);
		query_test("reset_gpio_inten", `BASICS_CMD_QRY_GPIO, `BASICS_SEL_INTEN);

		chk0.begin_test("version_match");
		send_version(`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR);
		chk0.end_test();
		chk0.begin_test("version_mismatch");
		send_version(`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR + 8'd1);
		chk0.end_test();

		set_then_query("set_i2c_speed", 1'b0, `BASICS_SEL_SPEED, 1);
		set_then_query("set_i2c_addr", 1'b0, `BASICS_SEL_ADDR, 2);
		set_then_query("set_gpio_level", 1'b1, `BASICS_SEL_LEVEL, 3);
		set_then_query("set_gpio_dir", 1'b1, `BASICS_SEL_DIR, 4);
		set_then_query("set_gpio_inten", 1'b1, `BASICS_SEL_INTEN, 5);

		drive_pins(rand24());
		query_test("gpio_pins_a", `BASICS_CMD_QRY_GPIO, `BASICS_SEL_READ);
		drive_pins(rand24());
		query_test("gpio_pins_b", `BASICS_CMD_QRY_GPIO, `BASICS_SEL_READ);

		chk0.begin_test("bad_selector");
		send_set(`BASICS_CMD_SET_I2C, "x", rand24(), 1);
		chk0.end_test();
		chk0.begin_test("short_set");
		send_set(`BASICS_CMD_SET_GPIO, `BASICS_SEL_LEVEL, rand24(), 2);
		chk0.end_test();
		chk0.begin_test("set_gpio_pins");
		send_set(`BASICS_CMD_SET_GPIO, `BASICS_SEL_READ, rand24(), 3);
		chk0.end_test();

		// A later good set commits every stage, so leftovers would show here
		chk0.begin_test("settings_unchanged");
		send_set(`BASICS_CMD_SET_I2C, `BASICS_SEL_SPEED, rand24(), 1);
		chk0.check_setting(1, model_value(1));
		chk0.check_setting(2, model_value(2));
		chk0.check_setting(3, model_value(3));
		chk0.check_setting(4, model_value(4));
		chk0.check_setting(5, model_value(5));
		send_query(`BASICS_CMD_QRY_I2C, `BASICS_SEL_ADDR);
		send_query(`BASICS_CMD_QRY_GPIO, `BASICS_SEL_LEVEL);
		send_query(`BASICS_CMD_QRY_GPIO, `BASICS_SEL_DIR);
		send_query(`BASICS_CMD_QRY_GPIO, `BASICS_SEL_INTEN);
		chk0.end_test();

		chk0.begin_test("unknown_command");
		begin_frame(8'h55);
		tx.push_back(`BASICS_SEL_SPEED);
		run_cmd();
		send_version(`BASICS_VERSION_MAJOR, `BASICS_VERSION_MINOR);
		chk0.end_test();

		$display("tests %0d passed %0d failed %0d errors %0d",
			chk0.pass_count + chk0.fail_count, chk0.pass_count, chk0.fail_count,
			chk0.error_count);
		if (chk0.error_count == 0 && chk0.fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+hw
hw/basics_pkg.sv
hw/basics_ifs.sv
hw/cmd_frame_rx.sv
hw/param_bank.sv
hw/basics_ctrl.sv
hw/reply_framer.sv
hw/basics_int.sv
verification/tb_checker.sv
verification/tb_basics.sv

// ==== Bender.yml ====
package:
  name: basics

export_include_dirs:
  - hw

sources:
  - files:
      - hw/basics_pkg.sv
      - hw/basics_ifs.sv
      - hw/cmd_frame_rx.sv
      - hw/param_bank.sv
      - hw/basics_ctrl.sv
      - hw/reply_framer.sv
      - hw/basics_int.sv
  - target: simulation
    files:
      - verification/tb_checker.sv
      - verification/tb_basics.sv
